// ==== files.f ====
+incdir+.
privArchPkg.sv
csrPortPkg.sv
csrConfigRegs.sv
trapControl.sv
trapRecordBank.sv
csrReadMux.sv
csrFile.sv
csrFile_checker.sv
csrFileTb.sv

// ==== Bender.yml ====
package:
  name: csr_file

sources:
  - include_dirs:
      - .
    files:
      - privArchPkg.sv
      - csrPortPkg.sv
      - csrConfigRegs.sv
      - trapControl.sv
      - trapRecordBank.sv
      - csrReadMux.sv
      - csrFile.sv
      - target: test
        files:
          - csrFile_checker.sv
          - csrFileTb.sv

// ==== csrFileTb.sv ====
// ----------------------------------------------------------------------
// Table-driven testbench for csrFile, one table row per clock cycle
// Trap rows use data as pc and its inverse as the trap value
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "csrDefs_macros.svh"

module csrFileTb;

    localparam logic [2:0] OpIdle  = 3'd0;
    localparam logic [2:0] OpWrite = 3'd1;
    localparam logic [2:0] OpRead  = 3'd2;
    localparam logic [2:0] OpTrap  = 3'd3;
    localparam logic [2:0] OpRet   = 3'd4;
    localparam logic [1:0] LvlU = 2'd0;
    localparam logic [1:0] LvlS = 2'd1;
    localparam logic [1:0] LvlM = 2'd3;
    localparam int ResetCycles = 4;

    typedef struct packed {
        logic [2:0]  op;
        logic [11:0] addrOrCause;
        logic [31:0] data;
        logic [1:0]  retFrom;
        logic [31:0] expRead;
        logic [31:0] expPc;
        logic [1:0]  expPriv;
    } stimRow_t;

    logic                    clk;
    logic                    rst;
    csrPortPkg::csrAccess_t  access;
    csrPortPkg::trapEvent_t  trap;
    csrPortPkg::trapReturn_t trapRet;
    logic [`XLEN-1:0]        readValue;
    logic [`XLEN-1:0]        nextPc;
    privArchPkg::status_t    mstatus;
    privArchPkg::privilege_t privilege;

    stimRow_t rows[$];
    int       cycleCount = 0;
    int       cycleLimit = 1000;

    csrFile csrFile_i (
        .clk, .rst, .access, .trap, .trapRet, .readValue, .nextPc, .mstatus, .privilege
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            abortRun($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h",
                               name, actual, expected));
        end
    endtask

    task automatic addRow(input logic [2:0] op, input logic [11:0] addr,
                          input logic [31:0] data, input logic [1:0] retFrom,
                          input logic [31:0] expRead, input logic [31:0] expPc,
                          input logic [1:0] expPriv);
        stimRow_t r;
        r = '{op, addr, data, retFrom, expRead, expPc, expPriv};
        rows.push_back(r);
    endtask

    // Non-blocking drive of one row on the current rising edge
    task automatic driveRow(input stimRow_t r);
        csrPortPkg::csrAccess_t  a;
        csrPortPkg::trapEvent_t  t;
        csrPortPkg::trapReturn_t ret;
        a = '0;
        t = '0;
        ret = '0;
        case (r.op)
            OpWrite: begin
                a.writeEnable = 1'b1;
                a.writeAddr   = r.addrOrCause;
                a.writeValue  = r.data;
            end
            OpRead: begin
                a.readEnable = 1'b1;
                a.readAddr   = r.addrOrCause;
            end
            OpTrap: begin
                t.valid = 1'b1;
                t.cause = r.addrOrCause[`CAUSE_W-1:0];
                t.pc    = r.data;
                t.value = ~r.data;
            end
            OpRet: begin
                ret.valid = 1'b1;
                ret.from  = privArchPkg::privilege_t'(r.retFrom);
            end
            default: ;
        endcase
        access  <= a;
        trap    <= t;
        trapRet <= ret;
    endtask

    // Expected values follow the privilege rules by hand
    task automatic buildTable();
        addRow(OpRead,  `CSR_MSTATUS,  32'h0,         LvlU, 32'h0,         32'h0, LvlM);
        // RV32I with MXL = 1
        addRow(OpRead,  `CSR_MISA,     32'h0,         LvlU, 32'h4000_0100, 32'h0, LvlM);
        addRow(OpWrite, `CSR_MSCRATCH, 32'h1234_5678, LvlU, 32'h0,         32'h0, LvlM);
        addRow(OpRead,  `CSR_MSCRATCH, 32'h0,         LvlU, 32'h1234_5678, 32'h0, LvlM);
        addRow(OpWrite, `CSR_SSCRATCH, 32'hCAFE_F00D, LvlU, 32'h0,         32'h0, LvlM);
        addRow(OpRead,  `CSR_SSCRATCH, 32'h0,         LvlU, 32'hCAFE_F00D, 32'h0, LvlM);
        // mtvec vectored at 0x1000, stvec direct at 0x2000
        addRow(OpWrite, `CSR_MTVEC,    32'h0000_1001, LvlU, 32'h0,         32'h0, LvlM);
        addRow(OpRead,  `CSR_MTVEC,    32'h0,         LvlU, 32'h0000_1001, 32'h0, LvlM);
        addRow(OpWrite, `CSR_STVEC,    32'h0000_2000, LvlU, 32'h0,         32'h0, LvlM);
        addRow(OpRead,  `CSR_STVEC,    32'h0,         LvlU, 32'h0000_2000, 32'h0, LvlM);
        addRow(OpWrite, `CSR_MEDELEG,  32'h0000_0100, LvlU, 32'h0,         32'h0, LvlM);
        addRow(OpRead,  `CSR_MEDELEG,  32'h0,         LvlU, 32'h0000_0100, 32'h0, LvlM);
        addRow(OpRead,  12'h7C0,       32'h0,         LvlU, 32'h0,         32'h0, LvlM);
        // Status masking, sie/spie/spp then all implemented bits
        addRow(OpWrite, `CSR_SSTATUS,  32'hFFFF_FFFF, LvlU, 32'h0,         32'h0, LvlM);
        addRow(OpRead,  `CSR_MSTATUS,  32'h0,         LvlU, 32'h0000_0122, 32'h0, LvlM);
        addRow(OpWrite, `CSR_MSTATUS,  32'hFFFF_FFFF, LvlU, 32'h0,         32'h0, LvlM);
        addRow(OpRead,  `CSR_MSTATUS,  32'h0,         LvlU, 32'h0040_19AA, 32'h0, LvlM);
        addRow(OpWrite, `CSR_MSTATUS,  32'h0,         LvlU, 32'h0,         32'h0, LvlM);
        // Machine trap, cause 2 is not delegated
        addRow(OpTrap,  12'd2,         32'h8000_0040, LvlU, 32'h0, 32'h0000_1008, LvlM);
        addRow(OpRead,  `CSR_MEPC,     32'h0,         LvlU, 32'h8000_0040, 32'h0, LvlM);
        addRow(OpRead,  `CSR_MCAUSE,   32'h0,         LvlU, 32'h0000_0002, 32'h0, LvlM);
        addRow(OpRead,  `CSR_MTVAL,    32'h0,         LvlU, 32'h7FFF_FFBF, 32'h0, LvlM);
        addRow(OpRead,  `CSR_MSTATUS,  32'h0,         LvlU, 32'h0000_1800, 32'h0, LvlM);
        // mret into supervisor with mpie set
        addRow(OpWrite, `CSR_MSTATUS,  32'h0000_0880, LvlU, 32'h0,         32'h0, LvlM);
        addRow(OpRet,   12'd0,         32'h0,         LvlM, 32'h0, 32'h8000_0040, LvlS);
        addRow(OpRead,  `CSR_MSTATUS,  32'h0,         LvlU, 32'h0000_0088, 32'h0, LvlS);
        // Delegated trap, cause 8, then sret
        addRow(OpWrite, `CSR_SSTATUS,  32'h0000_0020, LvlU, 32'h0,         32'h0, LvlS);
        addRow(OpTrap,  12'd8,         32'h0040_0010, LvlU, 32'h0, 32'h0000_2000, LvlS);
        addRow(OpRead,  `CSR_SEPC,     32'h0,         LvlU, 32'h0040_0010, 32'h0, LvlS);
        addRow(OpRead,  `CSR_SCAUSE,   32'h0,         LvlU, 32'h0000_0008, 32'h0, LvlS);
        addRow(OpRead,  `CSR_STVAL,    32'h0,         LvlU, 32'hFFBF_FFEF, 32'h0, LvlS);
        addRow(OpRead,  `CSR_SSTATUS,  32'h0,         LvlU, 32'h0000_0120, 32'h0, LvlS);
        addRow(OpRet,   12'd0,         32'h0,         LvlS, 32'h0, 32'h0040_0010, LvlS);
        addRow(OpRead,  `CSR_MSTATUS,  32'h0,         LvlU, 32'h0000_00AA, 32'h0, LvlS);
        // Second sret drops to user, then a delegated trap from user
        addRow(OpRet,   12'd0,         32'h0,         LvlS, 32'h0, 32'h0040_0010, LvlU);
        addRow(OpTrap,  12'd8,         32'h0040_0020, LvlU, 32'h0, 32'h0000_2000, LvlS);
        addRow(OpRead,  `CSR_SSTATUS,  32'h0,         LvlU, 32'h0000_0022, 32'h0, LvlS);
        // Trap from supervisor to machine, mpp records S
        addRow(OpTrap,  12'd3,         32'h0000_0ABC, LvlU, 32'h0, 32'h0000_100C, LvlM);
        addRow(OpRead,  `CSR_MSTATUS,  32'h0,         LvlU, 32'h0000_08AA, 32'h0, LvlM);
        addRow(OpRead,  `CSR_MCAUSE,   32'h0,         LvlU, 32'h0000_0003, 32'h0, LvlM);
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            abortRun($sformatf("Timeout: run did not finish within %0d cycles", cycleLimit));
        end
    end

    initial begin
        logic [1:0] prevPriv;
        stimRow_t   idleRow;
        idleRow = '0;
        idleRow.op = OpIdle;
        rst = 1'b1;
        access = '0;
        trap = '0;
        trapRet = '0;
        buildTable();
        cycleLimit = 4 * rows.size() + ResetCycles;
        repeat (ResetCycles) @(posedge clk);
        rst <= 1'b0;
        prevPriv = LvlM;
        // Privilege of each row is checked one cycle later
        foreach (rows[i]) begin
            @(posedge clk);
            driveRow(rows[i]);
            @(negedge clk);
            checkValue("privilege", {30'd0, privilege}, {30'd0, prevPriv});
            checkValue("readValue", readValue, rows[i].expRead);
            checkValue("nextPc", nextPc, rows[i].expPc);
            // The mstatus port must agree with the mstatus read
            if (rows[i].op == OpRead && rows[i].addrOrCause == `CSR_MSTATUS) begin
                checkValue("mstatus", mstatus, rows[i].expRead);
            end
            prevPriv = rows[i].expPriv;
        end
        @(posedge clk);
        driveRow(idleRow);
        @(negedge clk);
        checkValue("privilege", {30'd0, privilege}, {30'd0, prevPriv});
        if (csrFile_i.protocolChecks.failCount == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            abortRun("Assertion failures were reported during the run");
        end
    end

endmodule

// ==== csrFile_checker.sv ====
// ----------------------------------------------------------------------
// Protocol and output assertions for csrFile, attached with bind
// failCount counts assertion failures for the testbench summary
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "csrDefs_macros.svh"

module csrFile_checker (
    input logic                    clk,
    input logic                    rst,
    input csrPortPkg::csrAccess_t  access,
    input csrPortPkg::trapEvent_t  trap,
    input csrPortPkg::trapReturn_t trapRet,
    input logic [`XLEN-1:0]        readValue,
    input logic [`XLEN-1:0]        nextPc,
    input privArchPkg::privilege_t privilege
);

    int failCount = 0;

    // Encoding 2 is reserved
    privNotReserved: assert property (@(posedge clk) disable iff (rst)
        privilege != 2'b10)
    else begin
        $error("privilege holds the reserved encoding 2");
        failCount = failCount + 1;
    end

    trapNotWithReturn: assert property (@(posedge clk) disable iff (rst)
        !(trap.valid && trapRet.valid))
    else begin
        $error("trap and trap return asserted in the same cycle");
        failCount = failCount + 1;
    end

    readZeroWhenIdle: assert property (@(posedge clk) disable iff (rst)
        !access.readEnable |-> readValue == '0)
    else begin
        $error("readValue is not zero while readEnable is low");
        failCount = failCount + 1;
    end

    pcZeroWhenIdle: assert property (@(posedge clk) disable iff (rst)
        (!trap.valid && !trapRet.valid) |-> nextPc == '0)
    else begin
        $error("nextPc is not zero without a trap or return");
        failCount = failCount + 1;
    end

endmodule

bind csrFile csrFile_checker protocolChecks (
    .clk(clk), .rst(rst), .access(access), .trap(trap), .trapRet(trapRet),
    .readValue(readValue), .nextPc(nextPc), .privilege(privilege)
);

// ==== csrFile.sv ====
// ----------------------------------------------------------------------
// CSR file top level for an RV32 core with M and S modes
// Reads are combinational; writes and traps land on the next edge
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "csrDefs_macros.svh"

module csrFile (
    input  logic                    clk,
    input  logic                    rst,
    input  csrPortPkg::csrAccess_t  access,
    input  csrPortPkg::trapEvent_t  trap,
    input  csrPortPkg::trapReturn_t trapRet,
    output logic [`XLEN-1:0]        readValue,
    output logic [`XLEN-1:0]        nextPc,
    output privArchPkg::status_t    mstatus,
    output privArchPkg::privilege_t privilege
);

    privArchPkg::privilege_t nextPrivilege;
    privArchPkg::status_t    nextStatus;
    privArchPkg::tvec_t      mtvec;
    privArchPkg::tvec_t      stvec;
    csrPortPkg::trapTarget_t target;
    logic [`XLEN-1:0]        mscratch;
    logic [`XLEN-1:0]        sscratch;
    logic [`XLEN-1:0]        medeleg;
    logic [`XLEN-1:0]        mepc;
    logic [`XLEN-1:0]        sepc;
    logic [`XLEN-1:0]        mtval;
    logic [`XLEN-1:0]        stval;
    logic [`CAUSE_W-1:0]     mcause;
    logic [`CAUSE_W-1:0]     scause;

    csrConfigRegs configRegs (
        .clk, .rst, .access, .nextPrivilege, .nextStatus, .privilege,
        .status(mstatus), .mtvec, .stvec, .mscratch, .sscratch, .medeleg
    );

    trapControl trapLogic (
        .access, .trap, .trapRet, .privilege, .status(mstatus), .mtvec, .stvec,
        .medeleg, .mepc, .sepc, .target, .nextPrivilege, .nextStatus, .nextPc
    );

    // ------------------------------------------------------------------
    // Trap records, one bank per privilege level
    // ------------------------------------------------------------------
    trapRecordBank #(
        .EpcAddr(`CSR_MEPC), .CauseAddr(`CSR_MCAUSE), .TvalAddr(`CSR_MTVAL)
    ) machineRecords (
        .clk, .rst, .capture(target.toMachine), .trap, .access,
        .epc(mepc), .tval(mtval), .cause(mcause)
    );

    trapRecordBank #(
        .EpcAddr(`CSR_SEPC), .CauseAddr(`CSR_SCAUSE), .TvalAddr(`CSR_STVAL)
    ) supervisorRecords (
        .clk, .rst, .capture(target.toSupervisor), .trap, .access,
        .epc(sepc), .tval(stval), .cause(scause)
    );

    csrReadMux readMux (
        .access, .status(mstatus), .mtvec, .stvec, .mscratch, .sscratch, .medeleg,
        .mepc, .sepc, .mtval, .stval, .mcause, .scause, .readValue
    );

endmodule

// ==== csrReadMux.sv ====
// ----------------------------------------------------------------------
// CSR read decode; unknown addresses and ID registers read zero
// Causes read with the interrupt bit clear
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "csrDefs_macros.svh"

module csrReadMux (
    input  csrPortPkg::csrAccess_t access,
    input  privArchPkg::status_t   status,
    input  privArchPkg::tvec_t     mtvec,
    input  privArchPkg::tvec_t     stvec,
    input  logic [`XLEN-1:0]       mscratch,
    input  logic [`XLEN-1:0]       sscratch,
    input  logic [`XLEN-1:0]       medeleg,
    input  logic [`XLEN-1:0]       mepc,
    input  logic [`XLEN-1:0]       sepc,
    input  logic [`XLEN-1:0]       mtval,
    input  logic [`XLEN-1:0]       stval,
    input  logic [`CAUSE_W-1:0]    mcause,
    input  logic [`CAUSE_W-1:0]    scause,
    output logic [`XLEN-1:0]       readValue
);

    localparam int CausePad = `XLEN - `CAUSE_W;

    always_comb begin
        readValue = '0;
        if (access.readEnable) begin
            case (access.readAddr)
                `CSR_MSTATUS:  readValue = status;
                `CSR_SSTATUS:  readValue = status & `SSTATUS_MASK;
                `CSR_MISA:     readValue = `MISA_VALUE;
                `CSR_MEDELEG:  readValue = medeleg;
                `CSR_MTVEC:    readValue = mtvec;
                `CSR_STVEC:    readValue = stvec;
                `CSR_MSCRATCH: readValue = mscratch;
                `CSR_SSCRATCH: readValue = sscratch;
                `CSR_MEPC:     readValue = mepc;
                `CSR_SEPC:     readValue = sepc;
                `CSR_MCAUSE:   readValue = {{CausePad{1'b0}}, mcause};
                `CSR_SCAUSE:   readValue = {{CausePad{1'b0}}, scause};
                `CSR_MTVAL:    readValue = mtval;
                `CSR_STVAL:    readValue = stval;
                default:       readValue = '0;
            endcase
        end
    end

endmodule

// ==== trapRecordBank.sv ====
// ----------------------------------------------------------------------
// epc, cause and tval for one privilege level
// A trap capture wins over a CSR write in the same cycle
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "csrDefs_macros.svh"

module trapRecordBank #(
    parameter logic [`CSR_ADDR_W-1:0] EpcAddr   = `CSR_MEPC,
    parameter logic [`CSR_ADDR_W-1:0] CauseAddr = `CSR_MCAUSE,
    parameter logic [`CSR_ADDR_W-1:0] TvalAddr  = `CSR_MTVAL
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   capture,
    input  csrPortPkg::trapEvent_t trap,
    input  csrPortPkg::csrAccess_t access,
    output logic [`XLEN-1:0]       epc,
    output logic [`XLEN-1:0]       tval,
    output logic [`CAUSE_W-1:0]    cause
);

    logic writeEpc;
    logic writeCause;
    logic writeTval;

    assign writeEpc   = access.writeEnable && (access.writeAddr == EpcAddr);
    assign writeCause = access.writeEnable && (access.writeAddr == CauseAddr);
    assign writeTval  = access.writeEnable && (access.writeAddr == TvalAddr);

    always_ff @(posedge clk) begin
        if (rst) begin
            epc   <= '0;
            cause <= '0;
            tval  <= '0;
        end else if (capture) begin
            epc   <= trap.pc;
            cause <= trap.cause;
            tval  <= trap.value;
        end else begin
            if (writeEpc) begin
                epc <= access.writeValue;
            end
            // Upper cause bits are not stored
            if (writeCause) begin
                cause <= access.writeValue[`CAUSE_W-1:0];
            end
            if (writeTval) begin
                tval <= access.writeValue;
            end
        end
    end

endmodule

// ==== trapControl.sv ====
// ----------------------------------------------------------------------
// Combinational trap entry, trap return and status write logic
// Delegation follows medeleg alone; no interrupts are handled
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "csrDefs_macros.svh"

module trapControl (
    input  csrPortPkg::csrAccess_t  access,
    input  csrPortPkg::trapEvent_t  trap,
    input  csrPortPkg::trapReturn_t trapRet,
    input  privArchPkg::privilege_t privilege,
    input  privArchPkg::status_t    status,
    input  privArchPkg::tvec_t      mtvec,
    input  privArchPkg::tvec_t      stvec,
    input  logic [`XLEN-1:0]        medeleg,
    input  logic [`XLEN-1:0]        mepc,
    input  logic [`XLEN-1:0]        sepc,
    output csrPortPkg::trapTarget_t target,
    output privArchPkg::privilege_t nextPrivilege,
    output privArchPkg::status_t    nextStatus,
    output logic [`XLEN-1:0]        nextPc
);

    // Handler address, base * 4 plus cause * 4 when vectored
    function automatic logic [`XLEN-1:0] handlerAddr(privArchPkg::tvec_t vec,
                                                     logic [`CAUSE_W-1:0] cause);
        logic [`XLEN-3:0] slot;
        slot = vec.base;
        if (vec.mode == privArchPkg::TVEC_VECTORED) begin
            slot = vec.base + {{(`XLEN-2-`CAUSE_W){1'b0}}, cause};
        end
        return {slot, 2'b00};
    endfunction

    logic writeMstatus;
    logic writeSstatus;
    privArchPkg::status_t mergedStatus;

    assign writeMstatus = access.writeEnable && (access.writeAddr == `CSR_MSTATUS);
    assign writeSstatus = access.writeEnable && (access.writeAddr == `CSR_SSTATUS);

    always_comb begin
        target.toSupervisor = trap.valid && medeleg[trap.cause];
        target.toMachine    = trap.valid && !medeleg[trap.cause];
    end

    // Masked status write, reserved mpp encoding keeps the old level
    always_comb begin
        if (writeMstatus) begin
            mergedStatus = privArchPkg::status_t'((status & ~`MSTATUS_MASK)
                                                  | (access.writeValue & `MSTATUS_MASK));
            if (mergedStatus.mpp == 2'b10) begin
                mergedStatus.mpp = status.mpp;
            end
        end else begin
            mergedStatus = privArchPkg::status_t'((status & ~`SSTATUS_MASK)
                                                  | (access.writeValue & `SSTATUS_MASK));
        end
    end

    // Priority is trap, then return, then status write
    always_comb begin
        nextPrivilege = privilege;
        nextStatus    = status;
        nextPc        = '0;
        if (trap.valid) begin
            if (target.toSupervisor) begin
                nextPrivilege  = privArchPkg::PRIV_SUPERVISOR;
                nextStatus.spp = privilege[0];
                nextPc         = handlerAddr(stvec, trap.cause);
            end else begin
                nextPrivilege  = privArchPkg::PRIV_MACHINE;
                nextStatus.mpp = privilege;
                nextPc         = handlerAddr(mtvec, trap.cause);
            end
        end else if (trapRet.valid) begin
            if (trapRet.from == privArchPkg::PRIV_MACHINE) begin
                nextPrivilege  = status.mpp;
                nextStatus.mie = status.mpie;
                nextStatus.mpp = privArchPkg::PRIV_USER;
                nextPc         = mepc;
            end else if (trapRet.from == privArchPkg::PRIV_SUPERVISOR) begin
                nextPrivilege  = privArchPkg::privilege_t'({1'b0, status.spp});
                nextStatus.sie = status.spie;
                nextStatus.spp = 1'b0;
                nextPc         = sepc;
            end
        end else if (writeMstatus || writeSstatus) begin
            nextStatus = mergedStatus;
        end
    end

endmodule

// ==== csrConfigRegs.sv ====
// ----------------------------------------------------------------------
// Privilege, status, trap vectors, scratch registers and medeleg
// Status and privilege follow trapControl every cycle
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "csrDefs_macros.svh"

module csrConfigRegs (
    input  logic                    clk,
    input  logic                    rst,
    input  csrPortPkg::csrAccess_t  access,
    input  privArchPkg::privilege_t nextPrivilege,
    input  privArchPkg::status_t    nextStatus,
    output privArchPkg::privilege_t privilege,
    output privArchPkg::status_t    status,
    output privArchPkg::tvec_t      mtvec,
    output privArchPkg::tvec_t      stvec,
    output logic [`XLEN-1:0]        mscratch,
    output logic [`XLEN-1:0]        sscratch,
    output logic [`XLEN-1:0]        medeleg
);

    logic writeMtvec;
    logic writeStvec;
    logic writeMscratch;
    logic writeSscratch;
    logic writeMedeleg;

    // Write address decode
    always_comb begin
        writeMtvec    = access.writeEnable && (access.writeAddr == `CSR_MTVEC);
        writeStvec    = access.writeEnable && (access.writeAddr == `CSR_STVEC);
        writeMscratch = access.writeEnable && (access.writeAddr == `CSR_MSCRATCH);
        writeSscratch = access.writeEnable && (access.writeAddr == `CSR_SSCRATCH);
        writeMedeleg  = access.writeEnable && (access.writeAddr == `CSR_MEDELEG);
    end

    // ------------------------------------------------------------------
    // Trap state, updated every cycle
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            privilege <= privArchPkg::PRIV_MACHINE;
            status    <= '0;
        end else begin
            privilege <= nextPrivilege;
            status    <= nextStatus;
        end
    end

    // ------------------------------------------------------------------
    // Registers written only by CSR instructions
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec    <= '0;
            stvec    <= '0;
            mscratch <= '0;
            sscratch <= '0;
            medeleg  <= '0;
        end else begin
            if (writeMtvec) begin
                mtvec <= privArchPkg::tvec_t'(access.writeValue);
            end
            if (writeStvec) begin
                stvec <= privArchPkg::tvec_t'(access.writeValue);
            end
            if (writeMscratch) begin
                mscratch <= access.writeValue;
            end
            if (writeSscratch) begin
                sscratch <= access.writeValue;
            end
            // One bit per exception cause
            if (writeMedeleg) begin
                medeleg <= access.writeValue;
            end
        end
    end

endmodule

// ==== csrPortPkg.sv ====
// ----------------------------------------------------------------------
// Port bundles between the core and the CSR file
// All requests are single-cycle strobes without back-pressure
// ----------------------------------------------------------------------
`include "csrDefs_macros.svh"

package csrPortPkg;

    // CSR read and write strobes
    typedef struct packed {
        logic                    readEnable;
        logic [`CSR_ADDR_W-1:0]  readAddr;
        logic                    writeEnable;
        logic [`CSR_ADDR_W-1:0]  writeAddr;
        logic [`XLEN-1:0]        writeValue;
    } csrAccess_t;

    // Exception raised by the core
    typedef struct packed {
        logic                  valid;
        logic [`CAUSE_W-1:0]   cause;
        logic [`XLEN-1:0]      value;
        logic [`XLEN-1:0]      pc;
    } trapEvent_t;

    // mret or sret, keyed on the level being left
    typedef struct packed {
        logic                    valid;
        privArchPkg::privilege_t from;
    } trapReturn_t;

    // Which record bank takes the trap
    typedef struct packed {
        logic toMachine;
        logic toSupervisor;
    } trapTarget_t;

endpackage

// ==== privArchPkg.sv ====
// ----------------------------------------------------------------------
// Architectural register layouts shared by the CSR file
// mstatus keeps only sie, mie, spie, mpie, spp, mpp and tsr
// ----------------------------------------------------------------------
`include "csrDefs_macros.svh"

package privArchPkg;

    // Privilege levels, encoding 2 is reserved
    typedef enum logic [1:0] {
        PRIV_USER       = 2'd0,
        PRIV_SUPERVISOR = 2'd1,
        PRIV_MACHINE    = 2'd3
    } privilege_t;

    // mstatus layout, reserved spans read zero
    typedef struct packed {
        logic [8:0]  reserved31;
        logic        tsr;
        logic [8:0]  reserved21;
        privilege_t  mpp;
        logic [1:0]  reserved10;
        logic        spp;
        logic        mpie;
        logic        reserved6;
        logic        spie;
        logic        reserved4;
        logic        mie;
        logic        reserved2;
        logic        sie;
        logic        reserved0;
    } status_t;

    // Trap vector modes
    typedef enum logic [1:0] {
        TVEC_DIRECT   = 2'd0,
        TVEC_VECTORED = 2'd1
    } tvecMode_t;

    // Base is word aligned, handler address is base * 4
    typedef struct packed {
        logic [`XLEN-3:0] base;
        tvecMode_t        mode;
    } tvec_t;

endpackage

// ==== csrDefs_macros.svh ====
// ----------------------------------------------------------------------
// Widths, CSR addresses and status masks for the RV32 CSR file
// Only machine and supervisor levels exist; user-level CSRs are absent
// ----------------------------------------------------------------------
`ifndef CSR_DEFS_MACROS_SVH
`define CSR_DEFS_MACROS_SVH

// Widths
`define XLEN        32
`define CSR_ADDR_W  12
`define CAUSE_W     4

// Supervisor trap setup and handling
`define CSR_SSTATUS   12'h100
`define CSR_STVEC     12'h105
`define CSR_SSCRATCH  12'h140
`define CSR_SEPC      12'h141
`define CSR_SCAUSE    12'h142
`define CSR_STVAL     12'h143

// Machine trap setup and handling
`define CSR_MSTATUS   12'h300
`define CSR_MISA      12'h301
`define CSR_MEDELEG   12'h302
`define CSR_MTVEC     12'h305
`define CSR_MSCRATCH  12'h340
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MTVAL     12'h343

// RV32I, MXL = 1
`define MISA_VALUE    32'h4000_0100

// sie, spie, spp
`define SSTATUS_MASK  32'h0000_0122
// sie, mie, spie, mpie, spp, mpp, tsr
`define MSTATUS_MASK  32'h0040_19AA

`endif
